// File: source/resampler_pkg.sv
// Resampler shared definitions
package resampler_pkg;

    localparam int NUM_CH       = 4;
    localparam int CH_W         = $clog2(NUM_CH);

    localparam int HALFDEPTH    = 16;              // Power of two
    localparam int DEPTH_W      = $clog2(HALFDEPTH);
    localparam int NUM_FIR      = 160;
    localparam int FIR_W        = 8;
    localparam int DECIM        = 147;
    localparam int BANK_W       = FIR_W + DEPTH_W;

    localparam int TIMESLICE    = 64;
    localparam int SLICE_W      = $clog2(TIMESLICE);

    localparam int MULT_LATENCY = 4;

    // Oversized to absorb input jitter
    localparam int RB_LEN       = 4 * HALFDEPTH;
    localparam int RB_W         = $clog2(RB_LEN);
    localparam int OFFSET_W     = DEPTH_W + 1;

    // Cycles spent in each wing state
    localparam int WING_CYCLES  = HALFDEPTH + MULT_LATENCY + 2;
    localparam int WCNT_W       = $clog2(WING_CYCLES);

    typedef logic signed [23:0] sample_t;          // Q1.23
    typedef logic [NUM_CH-1:0]  ch_mask_t;

    typedef enum logic [2:0] {
        READY,
        BEGIN_CYCLE,
        MULADD_RWING,
        PREP_LWING,
        MULADD_LWING,
        END_CYCLE,
        IDLE
    } core_state_e;

    typedef struct packed {
        ch_mask_t              pop;
        logic [OFFSET_W-1:0]   offset;
    } rb_req_t;

    typedef struct packed {
        ch_mask_t ack;
        sample_t  data;
    } resample_out_t;

endpackage

// File: source/sample_ringbuf.sv
// Per-channel sample ring buffer
`timescale 1ns/1ps

module sample_ringbuf
    import resampler_pkg::*;
(
    input  logic                clk,
    input  logic                rst,

    input  logic                we_i,
    input  sample_t             data_i,

    input  logic                pop_i,
    input  logic [OFFSET_W-1:0] offset_i,
    output sample_t             data_o
);

    sample_t mem [RB_LEN];

    logic [RB_W-1:0] wr_ptr;
    logic [RB_W-1:0] rd_ptr;    // Oldest sample
    logic [RB_W-1:0] rd_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (we_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1; // Drop oldest
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // Pointer arithmetic wraps naturally at RB_LEN
    assign rd_addr = rd_ptr + RB_W'(offset_i);
    assign data_o  = mem[rd_addr];

endmodule

// File: source/fixed_mult.sv
// Pipelined Q1.23 multiplier
`timescale 1ns/1ps

module fixed_mult
    import resampler_pkg::*;
(
    input  logic    clk,
    input  sample_t a_i,
    input  sample_t b_i,
    output sample_t p_o
);

    logic signed [47:0] full_prod;
    sample_t            pipe [MULT_LATENCY];

    assign full_prod = a_i * b_i;

    always_ff @(posedge clk) begin
        // Truncating shift right by 23
        pipe[0] <= full_prod[46:23];
        for (int i = 1; i < MULT_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign p_o = pipe[MULT_LATENCY-1];

endmodule

// File: source/channel_scheduler.sv
// Round-robin channel time slicer
`timescale 1ns/1ps

module channel_scheduler
    import resampler_pkg::*;
(
    input  logic            clk,
    input  logic            rst,

    input  ch_mask_t        pop_i,
    input  ch_mask_t        served_i,

    output logic [CH_W-1:0] active_ch_o,
    output logic            slice_start_o,
    output logic            req_pending_o
);

    ch_mask_t           req_latch;
    logic [SLICE_W-1:0] slice_cnt;
    logic               slice_end;

    // New requests win over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            req_latch <= '0;
        end else begin
            req_latch <= pop_i | (req_latch & ~served_i);
        end
    end

    assign slice_end = (slice_cnt == SLICE_W'(TIMESLICE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            slice_cnt     <= '0;
            active_ch_o   <= '0;
            slice_start_o <= 1'b1; // Channel 0 starts right away
        end else begin
            slice_cnt     <= slice_cnt + 1'b1;
            slice_start_o <= 1'b0;
            if (slice_end) begin
                slice_cnt     <= '0;
                active_ch_o   <= active_ch_o + 1'b1;
                slice_start_o <= 1'b1;
            end
        end
    end

    assign req_pending_o = req_latch[active_ch_o];

endmodule

// File: source/resampler_core.sv
// Polyphase FIR resampler core
`timescale 1ns/1ps

module resampler_core
    import resampler_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic [CH_W-1:0]        active_ch_i,
    input  logic                   slice_start_i,
    input  logic                   req_pending_i,
    output ch_mask_t               served_o,

    output logic [BANK_W-1:0]      bank_addr_o,
    input  sample_t                bank_data_i,

    output rb_req_t                rb_req_o,
    input  sample_t [NUM_CH-1:0]   rb_data_i,

    output sample_t                mult_a_o,
    output sample_t                mult_b_o,
    input  sample_t                mult_p_i,

    output resample_out_t          out_o
);

    core_state_e         state;
    logic                req_taken;     // Request seen at slice start
    logic [WCNT_W-1:0]   wing_cnt;
    logic [FIR_W-1:0]    phase_mem [NUM_CH];
    logic [FIR_W-1:0]    r_phase;
    logic [FIR_W-1:0]    wing_phase;
    logic [DEPTH_W-1:0]  tap_idx;
    logic [DEPTH_W-1:0]  off_cnt;
    ch_mask_t            pop_q;
    sample_t             acc;
    logic                lwing;
    logic                prod_valid;

    assign served_o = slice_start_i ? (ch_mask_t'(1) << active_ch_i) : '0;

    // Sequencer restarts at every slice
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= READY;
            req_taken <= 1'b0;
            wing_cnt  <= '0;
        end else if (slice_start_i) begin
            state     <= READY;
            req_taken <= req_pending_i;
        end else begin
            wing_cnt <= wing_cnt + 1'b1;
            case (state)
                READY:        state <= req_taken ? BEGIN_CYCLE : IDLE;
                BEGIN_CYCLE: begin
                    state    <= MULADD_RWING;
                    wing_cnt <= '0;
                end
                MULADD_RWING: begin
                    if (wing_cnt == WCNT_W'(WING_CYCLES - 1)) begin
                        state <= PREP_LWING;
                    end
                end
                PREP_LWING: begin
                    state    <= MULADD_LWING;
                    wing_cnt <= '0;
                end
                MULADD_LWING: begin
                    if (wing_cnt == WCNT_W'(WING_CYCLES - 1)) begin
                        state <= END_CYCLE;
                    end
                end
                END_CYCLE:    state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    // Phase memory and buffer pop on wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                phase_mem[i] <= '0;
            end
            r_phase <= '0;
            pop_q   <= '0;
        end else begin
            pop_q <= '0;
            if (state == BEGIN_CYCLE) begin
                r_phase <= phase_mem[active_ch_i];
            end
            if (state == END_CYCLE) begin
                if (r_phase >= FIR_W'(NUM_FIR - DECIM)) begin
                    phase_mem[active_ch_i] <= r_phase - FIR_W'(NUM_FIR - DECIM);
                    pop_q[active_ch_i]     <= 1'b1;
                end else begin
                    phase_mem[active_ch_i] <= r_phase + FIR_W'(DECIM);
                end
            end
        end
    end

    // Tap index and buffer offset walk
    always_ff @(posedge clk) begin
        off_cnt <= off_cnt - 1'b1;
        case (state)
            BEGIN_CYCLE: begin
                tap_idx <= DEPTH_W'(HALFDEPTH - 1);
                off_cnt <= DEPTH_W'(HALFDEPTH - 1);
            end
            MULADD_RWING: tap_idx <= tap_idx - 1'b1;
            PREP_LWING: begin
                tap_idx <= '0;
                off_cnt <= DEPTH_W'(HALFDEPTH - 1);
            end
            MULADD_LWING: tap_idx <= tap_idx + 1'b1;
            default: ;
        endcase
    end

    assign lwing      = (state == MULADD_LWING);
    assign wing_phase = lwing ? FIR_W'(NUM_FIR - 1) - r_phase : r_phase;
    assign bank_addr_o = {wing_phase, tap_idx};

    assign rb_req_o.pop    = pop_q;
    assign rb_req_o.offset = {~lwing, off_cnt};  // Right wing reads the upper half

    assign mult_a_o = rb_data_i[active_ch_i];
    assign mult_b_o = bank_data_i;

    // Products of this wing's first HALFDEPTH inputs
    assign prod_valid = (state == MULADD_RWING || lwing) &&
                        wing_cnt >= WCNT_W'(MULT_LATENCY) &&
                        wing_cnt <  WCNT_W'(MULT_LATENCY + HALFDEPTH);

    always_ff @(posedge clk) begin
        if (state == BEGIN_CYCLE) begin
            acc <= '0;
        end else if (prod_valid) begin
            acc <= acc + mult_p_i;   // Wraps at 24 bits
        end
    end

    assign out_o.ack  = (state == END_CYCLE) ? (ch_mask_t'(1) << active_ch_i) : '0;
    assign out_o.data = acc;

endmodule

// File: source/ringbuffered_resampler.sv
// Ring-buffered resampler top level
`timescale 1ns/1ps

module ringbuffered_resampler
    import resampler_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    input  ch_mask_t             wr_i,
    input  sample_t [NUM_CH-1:0] wr_data_i,

    input  ch_mask_t             pop_i,

    output logic [BANK_W-1:0]    bank_addr_o,
    input  sample_t              bank_data_i,

    output resample_out_t        out_o
);

    rb_req_t              rb_req;
    sample_t [NUM_CH-1:0] rb_data;
    logic [CH_W-1:0]      active_ch;
    logic                 slice_start;
    logic                 req_pending;
    ch_mask_t             served;
    sample_t              mult_a;
    sample_t              mult_b;
    sample_t              mult_p;

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_rb
        sample_ringbuf i_rb (
            .clk      (clk),
            .rst      (rst),
            .we_i     (wr_i[ch]),
            .data_i   (wr_data_i[ch]),
            .pop_i    (rb_req.pop[ch]),
            .offset_i (rb_req.offset),
            .data_o   (rb_data[ch])
        );
    end

    channel_scheduler i_sched (
        .clk           (clk),
        .rst           (rst),
        .pop_i         (pop_i),
        .served_i      (served),
        .active_ch_o   (active_ch),
        .slice_start_o (slice_start),
        .req_pending_o (req_pending)
    );

    resampler_core i_core (
        .clk           (clk),
        .rst           (rst),
        .active_ch_i   (active_ch),
        .slice_start_i (slice_start),
        .req_pending_i (req_pending),
        .served_o      (served),
        .bank_addr_o   (bank_addr_o),
        .bank_data_i   (bank_data_i),
        .rb_req_o      (rb_req),
        .rb_data_i     (rb_data),
        .mult_a_o      (mult_a),
        .mult_b_o      (mult_b),
        .mult_p_i      (mult_p),
        .out_o         (out_o)
    );

    fixed_mult i_mult (
        .clk (clk),
        .a_i (mult_a),
        .b_i (mult_b),
        .p_o (mult_p)
    );

endmodule

// File: verification/tb_resampler_checks.svh
// Resampler reference model and checks

ch_mask_t awaited;                        // Channels with an ack still due
string    test_name;
int       model_r [NUM_CH] = '{default: 0};
logic [(1 << FIR_W)-1:0] phases_seen = '0;  // Bank phases since the last ack

function automatic sample_t k_value(int ch);
    return sample_t'((ch + 1) * (1 << 20));
endfunction

function automatic sample_t coef_for_phase(int p);
    return sample_t'((p + 1) * (1 << 13));
endfunction

// Q1.23 product truncated toward minus infinity
function automatic sample_t q23_mul(sample_t a, sample_t b);
    longint prod;
    prod = longint'(a) * longint'(b);
    return sample_t'(prod >>> 23);
endfunction

function automatic sample_t expected_sum(int ch);
    int right;
    int left;
    right = int'(q23_mul(k_value(ch), coef_for_phase(model_r[ch])));
    left  = int'(q23_mul(k_value(ch), coef_for_phase(NUM_FIR - 1 - model_r[ch])));
    return sample_t'(HALFDEPTH * (right + left));  // Wraps at 24 bits
endfunction

task automatic advance_phase(int ch);
    model_r[ch] = model_r[ch] + DECIM;
    if (model_r[ch] >= NUM_FIR) begin
        model_r[ch] = model_r[ch] - NUM_FIR;
    end
endtask

task automatic report_mismatch(string test, string expected, string actual);
    $display("ERROR %s: expected %s, actual %s", test, expected, actual);
    stop_with_failure();
endtask

task automatic check_cycle();
    int      phase;
    sample_t want;
    phase = int'(bank_addr >> DEPTH_W);
    if (awaited != '0) begin
        assert (phase < NUM_FIR)
            else report_mismatch({test_name, " bank phase"},
                                 $sformatf("below %0d", NUM_FIR), $sformatf("%0d", phase));
        phases_seen[phase] = 1'b1;
    end
    assert ($onehot0(dut_out.ack))
        else report_mismatch({test_name, " ack one-hot"}, "at most one bit",
                             $sformatf("%b", dut_out.ack));
    assert ((dut_out.ack & ~awaited) == '0)
        else report_mismatch({test_name, " ack channel"}, $sformatf("within %b", awaited),
                             $sformatf("%b", dut_out.ack));
    for (int ch = 0; ch < NUM_CH; ch++) begin
        if (dut_out.ack[ch]) begin
            want = expected_sum(ch);
            assert (dut_out.data == want)
                else report_mismatch(
                    $sformatf("%s ch%0d sum at phase %0d", test_name, ch, model_r[ch]),
                    $sformatf("%0d", want), $sformatf("%0d", dut_out.data));
            // The sum is the same for every r, so both wing phases are checked on the bank
            assert (phases_seen[model_r[ch]] && phases_seen[NUM_FIR - 1 - model_r[ch]])
                else report_mismatch(
                    $sformatf("%s ch%0d wing phases", test_name, ch),
                    $sformatf("%0d and %0d on the bank",
                              model_r[ch], NUM_FIR - 1 - model_r[ch]),
                    "one or both never addressed");
            advance_phase(ch);
            awaited[ch] = 1'b0;
            phases_seen = '0;
        end
    end
endtask

// File: verification/tb_ringbuffered_resampler.sv
// Resampler testbench
`timescale 1ns/1ps

module tb_ringbuffered_resampler
    import resampler_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int PREFILL_WRITES = 40;
    localparam int WRITE_GAP      = 8;
    localparam int ACK_TIMEOUT    = (NUM_CH + 2) * TIMESLICE;
    localparam int PHASE_RUNS     = 12;
    localparam int RANDOM_ROUNDS  = 16;

    logic                 clk;
    logic                 rst;
    ch_mask_t             wr;
    sample_t [NUM_CH-1:0] wr_data;
    ch_mask_t             pop;
    logic [BANK_W-1:0]    bank_addr;
    sample_t              bank_data;
    resample_out_t        dut_out;
    int                   seed = 32'h2b4d_0576;

    ringbuffered_resampler i_dut (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr),
        .wr_data_i   (wr_data),
        .pop_i       (pop),
        .bank_addr_o (bank_addr),
        .bank_data_i (bank_data),
        .out_o       (dut_out)
    );

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    `include "tb_resampler_checks.svh"

    // Coefficient bank returns one value per phase
    assign bank_data = coef_for_phase(int'(bank_addr >> DEPTH_W));

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
        check_cycle();
    endtask

    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            tick();
        end
    endtask

    task automatic request(ch_mask_t mask);
        pop = mask;
        awaited = awaited | mask;
        tick();
        pop = '0;
    endtask

    task automatic wait_for_acks();
        int waited;
        waited = 0;
        while (awaited != '0) begin
            if (waited >= ACK_TIMEOUT) begin
                $display("Timeout in %s: no ack for channel mask %b within %0d cycles",
                         test_name, awaited, ACK_TIMEOUT);
                stop_with_failure();
            end
            tick();
            waited++;
        end
    endtask

    // Constant per-channel input with a prefill and then a slow trickle
    initial begin : input_writer
        wr = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            wr_data[ch] = k_value(ch);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        wr = '1;
        repeat (PREFILL_WRITES) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        wr = '0;
        forever begin
            repeat (WRITE_GAP - 1) @(posedge clk);
            #DRIVE_DELAY;
            wr = '1;
            @(posedge clk);
            #DRIVE_DELAY;
            wr = '0;
        end
    end

    initial begin : main_sequence
        ch_mask_t mask;
        rst = 1'b1;
        pop = '0;
        awaited = '0;
        test_name = "reset";
        idle_cycles(RESET_CYCLES);
        rst = 1'b0;

        test_name = "no_request";
        idle_cycles(NUM_CH * TIMESLICE);

        test_name = "phase_advance";
        for (int i = 0; i < PHASE_RUNS; i++) begin
            request(ch_mask_t'(1));
            wait_for_acks();
        end

        // Right after its ack the channel is far from its next slice
        test_name = "merged_request";
        request(ch_mask_t'(4));
        wait_for_acks();
        request(ch_mask_t'(4));
        tick();
        request(ch_mask_t'(4));
        wait_for_acks();
        idle_cycles(ACK_TIMEOUT);   // A second ack would show here

        test_name = "interleaved";
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            mask = ch_mask_t'($random(seed));
            if (mask == '0) begin
                mask = '1;
            end
            request(mask);
            wait_for_acks();
        end

        test_name = "quiet_tail";
        idle_cycles(ACK_TIMEOUT);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: ringbuffered_resampler.f
+incdir+verification
source/resampler_pkg.sv
source/sample_ringbuf.sv
source/fixed_mult.sv
source/channel_scheduler.sv
source/resampler_core.sv
source/ringbuffered_resampler.sv
verification/tb_ringbuffered_resampler.sv

// File: Makefile
TOOL      = verilator
TOP       = tb_ringbuffered_resampler
FILELIST  = ringbuffered_resampler.f
BUILD_DIR = obj_dir
LOG       = sim.log
FLAGS     = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_TEXT = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run the simulation, log in $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Test passed"; \
	else \
		echo "Test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
